// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_lc3b_pipe
OBJ_DIR ?= obj_dir
FILELIST ?= tb.f
VFLAGS ?= --binary --timing --assert

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  build  build the simulation only"
	@echo "  clean  remove the build directory"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: build
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "Testbench passed" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: bench/clock_gen.sv
`default_nettype none

module clock_gen #(
	parameter int PERIOD = 10
) (
	output logic clk
);

initial begin
	clk = 1'b0;
	forever begin
		#(PERIOD / 2) clk = ~clk;
	end
end

endmodule

`default_nettype wire

// File: bench/tb_lc3b_pipe.sv
`default_nettype none

module tb_lc3b_pipe;

localparam lc3b_types::lc3b_word reset_pc = 16'h0000;
localparam int n_runs = 6;
localparam int cycles_per_run = 400;
localparam lc3b_types::lc3b_word nop = 16'h0000;

logic clk;
logic rst_n;
lc3b_types::lc3b_word imem_rdata;
logic imem_resp;
lc3b_types::lc3b_word dmem_rdata;
logic dmem_resp;
lc3b_types::lc3b_word imem_addr;
logic imem_read;
lc3b_types::lc3b_word dmem_addr;
logic dmem_read;
logic dmem_write;
lc3b_types::lc3b_word dmem_wdata;

lc3b_types::lc3b_word rom [256];
lc3b_types::lc3b_word ram [256];
lc3b_types::lc3b_word store_addr_q [$];
lc3b_types::lc3b_word store_data_q [$];
lc3b_types::lc3b_word exp_addr_q [$];
lc3b_types::lc3b_word exp_data_q [$];
lc3b_types::lc3b_word fetch_log [$];
logic [31:0] lfsr_state = 32'h5239_9f85;
bit zero_latency;
int i_wait;
int d_wait;

clock_gen #(.PERIOD(10)) u_clock (.clk);

lc3b_pipe #(.RESET_PC(reset_pc)) i_dut (
	.clk, .rst_n,
	.imem_rdata, .imem_resp, .dmem_rdata, .dmem_resp,
	.imem_addr, .imem_read,
	.dmem_addr, .dmem_read, .dmem_write, .dmem_wdata
);

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic take_bit();
	logic b;
	b = lfsr_state[0];
	lfsr_state = b ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
	return b;
endfunction

function automatic int pick_latency();
	logic [1:0] bits;
	if (zero_latency) begin
		return 0;
	end
	bits[0] = take_bit();
	bits[1] = take_bit();
	return int'(bits);
endfunction

function automatic lc3b_types::lc3b_word ram_fill(int idx);
	return lc3b_types::lc3b_word'(idx * 16'h03a5) ^ 16'hc3c3;
endfunction

function automatic lc3b_types::lc3b_word enc_reg(lc3b_types::lc3b_opcode op,
		lc3b_types::lc3b_reg dr, lc3b_types::lc3b_reg sr1, lc3b_types::lc3b_reg sr2);
	return {op, dr, sr1, 3'b000, sr2};
endfunction

function automatic lc3b_types::lc3b_word enc_imm(lc3b_types::lc3b_opcode op,
		lc3b_types::lc3b_reg dr, lc3b_types::lc3b_reg sr1, int imm);
	return {op, dr, sr1, 1'b1, imm[4:0]};
endfunction

function automatic lc3b_types::lc3b_word enc_not(lc3b_types::lc3b_reg dr,
		lc3b_types::lc3b_reg sr);
	return {lc3b_types::op_not, dr, sr, 6'b111111};
endfunction

// ldr and str, r is the destination or the data register
function automatic lc3b_types::lc3b_word enc_mem(lc3b_types::lc3b_opcode op,
		lc3b_types::lc3b_reg r, lc3b_types::lc3b_reg base, int off6);
	return {op, r, base, off6[5:0]};
endfunction

// lea takes dr in the middle field, br takes nzp
function automatic lc3b_types::lc3b_word enc_pcrel(lc3b_types::lc3b_opcode op,
		logic [2:0] field, int off9);
	return {op, field, off9[8:0]};
endfunction

// memory models, answered 1 time unit after the edge
always @(posedge clk) begin
	#1;
	imem_resp = 1'b0;
	dmem_resp = 1'b0;
	if (!rst_n) begin
		i_wait = -1;
		d_wait = -1;
	end else begin
		if (imem_read) begin
			if (i_wait < 0) begin
				i_wait = pick_latency();
			end
			if (i_wait == 0) begin
				imem_resp = 1'b1;
				i_wait = -1;
				fetch_log.push_back(imem_addr);
			end else begin
				i_wait--;
			end
		end
		if (dmem_read || dmem_write) begin
			if (d_wait < 0) begin
				d_wait = pick_latency();
			end
			if (d_wait == 0) begin
				dmem_resp = 1'b1;
				d_wait = -1;
				if (dmem_write) begin
					ram[dmem_addr[8:1]] = dmem_wdata;
					store_addr_q.push_back(dmem_addr);
					store_data_q.push_back(dmem_wdata);
				end else begin
					dmem_rdata = ram[dmem_addr[8:1]];
				end
			end else begin
				d_wait--;
			end
		end else begin
			d_wait = -1;
		end
	end
	imem_rdata = rom[imem_addr[8:1]]; // read data follows the address
end

task automatic fail_run(input string msg);
	$display("%s", msg);
	$display("Testbench failed");
	$fatal(1);
endtask

task automatic check_word(input lc3b_types::lc3b_word got, input lc3b_types::lc3b_word exp,
		input string what);
	if (got !== exp) begin
		fail_run($sformatf("** Error at %0t: %s data %h, expected %h", $time, what, got, exp));
	end
endtask

task automatic check_addr(input lc3b_types::lc3b_word got, input lc3b_types::lc3b_word exp,
		input string what);
	if (got !== exp) begin
		fail_run($sformatf("** Error at %0t: %s address %h, expected %h", $time, what, got, exp));
	end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		fail_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
	end
endtask

task automatic clear_memories();
	for (int i = 0; i < 256; i++) begin
		rom[i] = nop;
		ram[i] = ram_fill(i);
	end
	exp_addr_q.delete();
	exp_data_q.delete();
endtask

task automatic apply_reset();
	@(posedge clk);
	#1 rst_n = 1'b0;
	store_addr_q.delete();
	store_data_q.delete();
	fetch_log.delete();
	repeat (5) @(posedge clk);
	#1 rst_n = 1'b1;
endtask

task automatic run_program();
	apply_reset();
	while (store_addr_q.size() < exp_addr_q.size()) begin
		@(posedge clk);
	end
	repeat (40) @(posedge clk); // any late or repeated store shows up here
endtask

task automatic check_stores(input string what);
	if (store_addr_q.size() != exp_addr_q.size()) begin
		fail_run($sformatf("%s: the data port saw %0d stores instead of %0d", what,
			store_addr_q.size(), exp_addr_q.size()));
	end else begin
		foreach (exp_addr_q[k]) begin
			check_addr(store_addr_q[k], exp_addr_q[k], $sformatf("%s store %0d", what, k));
			check_word(store_data_q[k], exp_data_q[k], $sformatf("%s store %0d", what, k));
		end
	end
endtask

task automatic expect_store(input int addr, input lc3b_types::lc3b_word data);
	exp_addr_q.push_back(lc3b_types::lc3b_word'(addr));
	exp_data_q.push_back(data);
endtask

task automatic reset_and_fetch();
	clear_memories();
	apply_reset();
	check_addr(imem_addr, reset_pc, "first fetch");
	check_flag(dmem_read, 1'b0, "dmem_read after reset");
	check_flag(dmem_write, 1'b0, "dmem_write after reset");
	while (fetch_log.size() < 8) begin
		@(negedge clk);
		check_flag(dmem_read || dmem_write, 1'b0, "data strobe during nops");
	end
	foreach (fetch_log[k]) begin
		check_addr(fetch_log[k], reset_pc + lc3b_types::lc3b_word'(2 * k), "fetch");
	end
endtask

task automatic alu_results();
	lc3b_types::lc3b_word a;
	lc3b_types::lc3b_word b;
	clear_memories();
	rom[0] = enc_imm(lc3b_types::op_add, 3'd1, 3'd0, 7);
	rom[1] = enc_imm(lc3b_types::op_add, 3'd2, 3'd0, -3);
	rom[3] = enc_reg(lc3b_types::op_add, 3'd3, 3'd1, 3'd2);
	rom[4] = enc_reg(lc3b_types::op_and, 3'd4, 3'd1, 3'd2);
	rom[5] = enc_not(3'd5, 3'd1);
	rom[6] = enc_imm(lc3b_types::op_and, 3'd7, 3'd2, 12);
	rom[8] = enc_mem(lc3b_types::op_str, 3'd3, 3'd0, 1);
	rom[9] = enc_mem(lc3b_types::op_str, 3'd4, 3'd0, 2);
	rom[10] = enc_mem(lc3b_types::op_str, 3'd5, 3'd0, 3);
	rom[11] = enc_mem(lc3b_types::op_str, 3'd7, 3'd0, 4);
	rom[12] = enc_imm(lc3b_types::op_add, 3'd3, 3'd5, 15);
	rom[14] = enc_mem(lc3b_types::op_str, 3'd3, 3'd0, 5);
	rom[15] = enc_pcrel(lc3b_types::op_br, 3'b111, -1); // park here
	a = 16'd7;
	b = 16'hfffd;
	expect_store(2, a + b);
	expect_store(4, a & b);
	expect_store(6, ~a);
	expect_store(8, b & 16'd12);
	expect_store(10, ~a + 16'd15);
	run_program();
	check_stores("alu");
endtask

task automatic load_ldr_program();
	clear_memories();
	rom[0] = enc_imm(lc3b_types::op_add, 3'd1, 3'd0, 10);
	rom[2] = enc_mem(lc3b_types::op_ldr, 3'd2, 3'd1, 3);
	rom[3] = enc_mem(lc3b_types::op_ldr, 3'd3, 3'd1, -2);
	rom[5] = enc_mem(lc3b_types::op_str, 3'd2, 3'd1, -5);
	rom[6] = enc_mem(lc3b_types::op_str, 3'd3, 3'd1, 6);
	rom[7] = enc_reg(lc3b_types::op_add, 3'd4, 3'd2, 3'd3);
	rom[9] = enc_mem(lc3b_types::op_str, 3'd4, 3'd1, -1);
	rom[10] = enc_pcrel(lc3b_types::op_br, 3'b111, -1);
	// byte address is base plus twice offset6
	expect_store(10 - 10, ram_fill((10 + 6) / 2));
	expect_store(10 + 12, ram_fill((10 - 4) / 2));
	expect_store(10 - 2, ram_fill(8) + ram_fill(3));
endtask

task automatic ldr_str_addressing();
	load_ldr_program();
	run_program();
	check_stores("ldr/str");
endtask

task automatic branch_squash();
	clear_memories();
	rom[0] = enc_imm(lc3b_types::op_add, 3'd1, 3'd0, -1);
	rom[2] = enc_pcrel(lc3b_types::op_br, 3'b011, 3); // cc is n, falls through
	rom[3] = enc_mem(lc3b_types::op_str, 3'd1, 3'd0, 1);
	rom[4] = enc_imm(lc3b_types::op_add, 3'd2, 3'd0, 5);
	rom[6] = enc_pcrel(lc3b_types::op_br, 3'b001, 3); // to word 10
	rom[7] = enc_mem(lc3b_types::op_str, 3'd2, 3'd0, 2);
	rom[8] = enc_mem(lc3b_types::op_str, 3'd2, 3'd0, 3);
	rom[9] = enc_mem(lc3b_types::op_str, 3'd2, 3'd0, 4);
	rom[10] = enc_pcrel(lc3b_types::op_lea, 3'd3, 5);
	rom[12] = enc_mem(lc3b_types::op_str, 3'd3, 3'd0, 5);
	rom[13] = enc_pcrel(lc3b_types::op_br, 3'b100, 2);
	rom[14] = enc_mem(lc3b_types::op_str, 3'd2, 3'd0, 6);
	rom[15] = enc_pcrel(lc3b_types::op_br, 3'b111, -1);
	expect_store(2, 16'hffff);
	expect_store(10, 16'd22 + 16'd10); // lea at byte 20, pc + 2 * 5
	expect_store(12, 16'd5);
	run_program();
	check_stores("branch");
endtask

task automatic back_pressure();
	lc3b_types::lc3b_word ref_addr [$];
	lc3b_types::lc3b_word ref_data [$];
	zero_latency = 1'b1;
	load_ldr_program();
	run_program();
	check_stores("zero latency");
	ref_addr = store_addr_q;
	ref_data = store_data_q;
	zero_latency = 1'b0;
	load_ldr_program();
	run_program();
	check_stores("random latency");
	foreach (ref_addr[k]) begin
		check_addr(store_addr_q[k], ref_addr[k], $sformatf("replayed store %0d", k));
		check_word(store_data_q[k], ref_data[k], $sformatf("replayed store %0d", k));
	end
endtask

initial begin
	#(n_runs * cycles_per_run * 10);
	$display("the simulation ran out of time before all tests finished");
	$display("Testbench failed");
	$fatal(1);
end

initial begin
	rst_n = 1'b0;
	imem_rdata = nop;
	imem_resp = 1'b0;
	dmem_rdata = '0;
	dmem_resp = 1'b0;
	zero_latency = 1'b0;
	reset_and_fetch();
	alu_results();
	ldr_str_addressing();
	branch_squash();
	back_pressure();
	$display("Testbench passed");
	$finish;
end

endmodule

`default_nettype wire

// File: source/decode.sv
`default_nettype none

module decode (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic stall,
	input  wire logic flush,
	input  wire lc3b_types::if_id_t if_id,
	input  wire logic wb_load,
	input  wire lc3b_types::lc3b_reg wb_dest,
	input  wire lc3b_types::lc3b_word wb_data,
	output lc3b_types::id_ex_t id_ex
);

lc3b_types::lc3b_opcode opcode;
lc3b_types::lc3b_reg src_a;
lc3b_types::lc3b_reg src_b;
lc3b_types::lc3b_word sr1_val;
lc3b_types::lc3b_word sr2_val;
lc3b_types::lc3b_ctrl ctrl;
lc3b_types::id_ex_t id_ex_d;

assign opcode = lc3b_types::lc3b_opcode'(if_id.instr[15:12]);
assign src_a = if_id.instr[8:6];
assign src_b = (opcode == lc3b_types::op_str) ? if_id.instr[11:9] : if_id.instr[2:0]; // str data reg

regfile rf (
	.clk,
	.rst_n,
	.load(wb_load),
	.dest(wb_dest),
	.data(wb_data),
	.src_a,
	.src_b,
	.reg_a(sr1_val),
	.reg_b(sr2_val)
);

always_comb begin
	ctrl = '0; // anything not listed below is a nop
	ctrl.aluop = lc3b_types::alu_pass;
	case (opcode)
		lc3b_types::op_add, lc3b_types::op_and: begin
			ctrl.aluop = (opcode == lc3b_types::op_add) ? lc3b_types::alu_add
				: lc3b_types::alu_and;
			ctrl.srcb_sel = if_id.instr[5] ? lc3b_types::srcb_imm5 : lc3b_types::srcb_reg;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		lc3b_types::op_not: begin
			ctrl.aluop = lc3b_types::alu_not;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		lc3b_types::op_ldr: begin
			ctrl.aluop = lc3b_types::alu_add;
			ctrl.srcb_sel = lc3b_types::srcb_off6;
			ctrl.mem_read = 1'b1;
			ctrl.wb_sel = 1'b1;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		lc3b_types::op_str: begin
			ctrl.aluop = lc3b_types::alu_add;
			ctrl.srcb_sel = lc3b_types::srcb_off6;
			ctrl.mem_write = 1'b1;
		end
		lc3b_types::op_lea: begin
			ctrl.srca_sel = 1'b1;
			ctrl.aluop = lc3b_types::alu_add;
			ctrl.srcb_sel = lc3b_types::srcb_off9;
			ctrl.load_regfile = 1'b1; // lc-3b lea leaves cc alone
		end
		lc3b_types::op_br: begin
			ctrl.srca_sel = 1'b1;
			ctrl.aluop = lc3b_types::alu_add;
			ctrl.srcb_sel = lc3b_types::srcb_off9;
			ctrl.is_branch = 1'b1; // nzp 000 never taken
		end
		default: ;
	endcase
end

always_comb begin
	id_ex_d.pc = if_id.pc;
	id_ex_d.instr = if_id.instr;
	id_ex_d.ctrl = ctrl;
	id_ex_d.sr1_val = sr1_val;
	id_ex_d.sr2_val = sr2_val;
	id_ex_d.valid = if_id.valid;
end

pipe_reg #(.payload_t(lc3b_types::id_ex_t)) id_ex_reg (
	.clk,
	.rst_n,
	.load(!stall),
	.flush,
	.d(id_ex_d),
	.q(id_ex)
);

// a stalled instruction stays in ID_EX
a_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
	stall && id_ex.valid |=> id_ex.valid && $stable(id_ex.instr));

endmodule

`default_nettype wire

// File: source/execute.sv
`default_nettype none

module execute (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic stall,
	input  wire lc3b_types::id_ex_t id_ex,
	input  wire logic [2:0] cc,
	output logic branch_taken,
	output lc3b_types::lc3b_word branch_target,
	output lc3b_types::ex_mem_t ex_mem
);

lc3b_types::lc3b_word imm5_sext;
lc3b_types::lc3b_word off6_sext;
lc3b_types::lc3b_word off9_sext;
lc3b_types::lc3b_word alu_a;
lc3b_types::lc3b_word alu_b;
lc3b_types::lc3b_word alu_out;
lc3b_types::ex_mem_t ex_mem_d;

assign imm5_sext = {{11{id_ex.instr[4]}}, id_ex.instr[4:0]};
assign off6_sext = {{9{id_ex.instr[5]}}, id_ex.instr[5:0], 1'b0}; // word offsets
assign off9_sext = {{6{id_ex.instr[8]}}, id_ex.instr[8:0], 1'b0};

assign alu_a = id_ex.ctrl.srca_sel ? id_ex.pc : id_ex.sr1_val;

always_comb begin
	case (id_ex.ctrl.srcb_sel)
		lc3b_types::srcb_imm5: alu_b = imm5_sext;
		lc3b_types::srcb_off6: alu_b = off6_sext;
		lc3b_types::srcb_off9: alu_b = off9_sext;
		default: alu_b = id_ex.sr2_val;
	endcase
end

always_comb begin
	case (id_ex.ctrl.aluop)
		lc3b_types::alu_add: alu_out = alu_a + alu_b;
		lc3b_types::alu_and: alu_out = alu_a & alu_b;
		lc3b_types::alu_not: alu_out = ~alu_a;
		default: alu_out = alu_b;
	endcase
end

// nzp field of the branch against the committed cc
assign branch_taken = id_ex.valid && id_ex.ctrl.is_branch && |(id_ex.instr[11:9] & cc);
assign branch_target = alu_out;

always_comb begin
	ex_mem_d.alu_out = alu_out;
	ex_mem_d.store_data = id_ex.sr2_val;
	ex_mem_d.dest = id_ex.instr[11:9];
	ex_mem_d.ctrl = id_ex.ctrl;
	ex_mem_d.valid = id_ex.valid;
end

pipe_reg #(.payload_t(lc3b_types::ex_mem_t)) ex_mem_reg (
	.clk,
	.rst_n,
	.load(!stall),
	.flush(1'b0), // the branch itself is older than anything squashed
	.d(ex_mem_d),
	.q(ex_mem)
);

endmodule

`default_nettype wire

// File: source/fetch.sv
`default_nettype none

module fetch #(
	parameter lc3b_types::lc3b_word RESET_PC = 16'h0000
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic stall,
	input  wire logic branch_taken,
	input  wire lc3b_types::lc3b_word branch_target,
	input  wire lc3b_types::lc3b_word imem_rdata,
	input  wire logic imem_resp,
	output lc3b_types::lc3b_word imem_addr,
	output logic imem_read,
	output lc3b_types::if_id_t if_id
);

lc3b_types::lc3b_word pc;
lc3b_types::lc3b_word pc_plus2;
lc3b_types::if_id_t if_id_d;

assign pc_plus2 = pc + 16'd2;
assign imem_addr = pc;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		pc <= RESET_PC;
		imem_read <= 1'b0;
	end else begin
		imem_read <= 1'b1; // a new request follows every response
		if (!stall) begin
			if (branch_taken) begin
				pc <= branch_target;
			end else if (imem_resp) begin
				pc <= pc_plus2;
			end
		end
	end
end

always_comb begin
	if_id_d.pc = pc_plus2;
	if_id_d.instr = imem_rdata;
	if_id_d.valid = imem_resp; // no response, no instruction
end

pipe_reg #(.payload_t(lc3b_types::if_id_t)) if_id_reg (
	.clk,
	.rst_n,
	.load(!stall),
	.flush(branch_taken),
	.d(if_id_d),
	.q(if_id)
);

// the request must not move before the instruction memory answers
a_imem_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
	imem_read && !imem_resp |=> $stable(imem_addr));

endmodule

`default_nettype wire

// File: source/lc3b_pipe.sv
`default_nettype none

module lc3b_pipe #(
	parameter lc3b_types::lc3b_word RESET_PC = 16'h0000
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire lc3b_types::lc3b_word imem_rdata,
	input  wire logic imem_resp,
	input  wire lc3b_types::lc3b_word dmem_rdata,
	input  wire logic dmem_resp,
	output lc3b_types::lc3b_word imem_addr,
	output logic imem_read,
	output lc3b_types::lc3b_word dmem_addr,
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_types::lc3b_word dmem_wdata
);

lc3b_types::if_id_t if_id;
lc3b_types::id_ex_t id_ex;
lc3b_types::ex_mem_t ex_mem;
lc3b_types::lc3b_word branch_target;
lc3b_types::lc3b_word wb_data;
lc3b_types::lc3b_reg wb_dest;
logic [2:0] cc;
logic branch_taken;
logic flush;
logic stall;
logic wb_load;
logic mem_busy;
logic mem_read_req;
logic mem_write_req;
logic dmem_done;

// data access answered while fetch still waits, do not repeat it
always_ff @(posedge clk) begin
	if (!rst_n || !stall) begin
		dmem_done <= 1'b0;
	end else if (dmem_resp) begin
		dmem_done <= 1'b1;
	end
end

assign dmem_read = mem_read_req && !dmem_done;
assign dmem_write = mem_write_req && !dmem_done;
assign stall = (imem_read && !imem_resp) || (mem_busy && !dmem_done && !dmem_resp);
assign flush = branch_taken && !stall; // redirect only when the pipe moves

fetch #(.RESET_PC(RESET_PC)) u_fetch (
	.clk, .rst_n, .stall,
	.branch_taken(flush), .branch_target,
	.imem_rdata, .imem_resp, .imem_addr, .imem_read,
	.if_id
);

decode u_decode (
	.clk, .rst_n, .stall, .flush,
	.if_id, .wb_load, .wb_dest, .wb_data,
	.id_ex
);

execute u_execute (
	.clk, .rst_n, .stall,
	.id_ex, .cc,
	.branch_taken, .branch_target,
	.ex_mem
);

mem_wb u_mem_wb (
	.clk, .rst_n, .ex_mem,
	.dmem_rdata, .dmem_resp, .dmem_addr,
	.dmem_read(mem_read_req), .dmem_write(mem_write_req), .dmem_wdata,
	.wb_load, .wb_dest, .wb_data, .cc, .mem_busy
);

endmodule

`default_nettype wire

// File: source/lc3b_types.sv
`default_nettype none

package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} lc3b_aluop;

typedef enum logic [1:0] {
	srcb_reg,
	srcb_imm5,
	srcb_off6, // offset6 << 1
	srcb_off9  // offset9 << 1
} lc3b_srcb;

typedef struct packed {
	logic srca_sel; // 1 selects pc
	lc3b_srcb srcb_sel;
	lc3b_aluop aluop;
	logic load_regfile;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic is_branch;
	logic wb_sel; // 1 selects load data
} lc3b_ctrl;

typedef struct packed {
	lc3b_word pc; // already incremented
	lc3b_word instr;
	logic valid;
} if_id_t;

typedef struct packed {
	lc3b_word pc;
	lc3b_word instr;
	lc3b_ctrl ctrl;
	lc3b_word sr1_val;
	lc3b_word sr2_val;
	logic valid;
} id_ex_t;

typedef struct packed {
	lc3b_word alu_out; // result or address
	lc3b_word store_data;
	lc3b_reg dest;
	lc3b_ctrl ctrl;
	logic valid;
} ex_mem_t;

endpackage

`default_nettype wire

// File: source/mem_wb.sv
`default_nettype none

module mem_wb (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire lc3b_types::ex_mem_t ex_mem,
	input  wire lc3b_types::lc3b_word dmem_rdata,
	input  wire logic dmem_resp,
	output lc3b_types::lc3b_word dmem_addr,
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_types::lc3b_word dmem_wdata,
	output logic wb_load,
	output lc3b_types::lc3b_reg wb_dest,
	output lc3b_types::lc3b_word wb_data,
	output logic [2:0] cc,
	output logic mem_busy
);

logic [2:0] cc_next;

assign dmem_addr = ex_mem.alu_out;
assign dmem_wdata = ex_mem.store_data;
assign dmem_read = ex_mem.valid && ex_mem.ctrl.mem_read;
assign dmem_write = ex_mem.valid && ex_mem.ctrl.mem_write;
assign mem_busy = dmem_read || dmem_write; // top masks this once the access is done

assign wb_data = ex_mem.ctrl.wb_sel ? dmem_rdata : ex_mem.alu_out;
assign wb_dest = ex_mem.dest;
// loads write back only in their response cycle
assign wb_load = ex_mem.valid && ex_mem.ctrl.load_regfile && (!ex_mem.ctrl.mem_read || dmem_resp);

always_comb begin
	if (wb_data[15]) begin
		cc_next = 3'b100;
	end else if (wb_data == '0) begin
		cc_next = 3'b010;
	end else begin
		cc_next = 3'b001;
	end
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		cc <= 3'b010; // z
	end else if (wb_load && ex_mem.ctrl.load_cc) begin
		cc <= cc_next;
	end
end

// a new store that is not answered at once keeps its address
a_store_held: assert property (@(posedge clk) disable iff (!rst_n)
	$rose(dmem_write) && !dmem_resp |=> dmem_write && $stable(dmem_addr));

endmodule

`default_nettype wire

// File: source/pipe_reg.sv
`default_nettype none

module pipe_reg #(
	parameter type payload_t = lc3b_types::if_id_t
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic load,
	input  wire logic flush,
	input  wire payload_t d,
	output payload_t q
);

// only valid is cleared, the payload is don't-care while invalid
always_ff @(posedge clk) begin
	if (!rst_n || flush) begin
		q.valid <= 1'b0; // flush wins over load
	end else if (load) begin
		q <= d;
	end
end

endmodule

`default_nettype wire

// File: source/regfile.sv
`default_nettype none

module regfile (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic load,
	input  wire lc3b_types::lc3b_reg dest,
	input  wire lc3b_types::lc3b_word data,
	input  wire lc3b_types::lc3b_reg src_a,
	input  wire lc3b_types::lc3b_reg src_b,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);

lc3b_types::lc3b_word regs [8];

always_ff @(posedge clk) begin
	if (!rst_n) begin
		for (int i = 0; i < 8; i++) begin
			regs[i] <= '0;
		end
	end else if (load) begin
		regs[dest] <= data;
	end
end

// write-first, decode sees the value being written back
always_comb begin
	reg_a = (load && dest == src_a) ? data : regs[src_a];
	reg_b = (load && dest == src_b) ? data : regs[src_b];
end

endmodule

`default_nettype wire

// File: tb.f
source/lc3b_types.sv
source/pipe_reg.sv
source/fetch.sv
source/regfile.sv
source/decode.sv
source/execute.sv
source/mem_wb.sv
source/lc3b_pipe.sv
bench/clock_gen.sv
bench/tb_lc3b_pipe.sv
